// File: src/conv_pkg.sv
package conv_pkg;

    // data widths
    localparam int ACT_W  = 8;   // signed activation
    localparam int WGT_W  = 8;   // signed weight
    localparam int ACC_W  = 20;  // accumulator and result
    localparam int IDX_W  = 4;   // rf address / tap index, covers 12 words
    localparam int LANE_W = 4;   // lane number, up to 16 lanes

    // one weight write request, 17 bits
    typedef struct packed {
        logic              valid;
        logic [LANE_W-1:0] lane;  // target output-channel lane
        logic [IDX_W-1:0]  idx;   // word inside the lane rf
        logic [WGT_W-1:0]  data;
    } wgt_wr_t;

    // one activation tap, broadcast to every lane
    typedef struct packed {
        logic                    valid;
        logic                    last;  // closes the kernel window
        logic [IDX_W-1:0]        idx;   // tap number inside the window
        logic signed [ACT_W-1:0] act;
    } tap_t;

endpackage

// File: src/rf_2p.sv
`timescale 1ns/10ps

module rf_2p #(
    parameter int WORDS = 12,
    parameter int DWd   = 8
)(
    input  logic                        i_clk,
    input  logic                        i_write,
    input  logic [conv_pkg::IDX_W-1:0]  i_waddr,
    input  logic [DWd-1:0]              i_wdata,
    input  logic                        i_read,
    input  logic [conv_pkg::IDX_W-1:0]  i_raddr,
    output logic [DWd-1:0]              o_rdata
);

    logic [DWd-1:0] mem [WORDS];  // behavioural stand-in for the 2p macro

    // write port, addresses past the last word are ignored
    always_ff @(posedge i_clk) begin
        if (i_write && (int'(i_waddr) < WORDS)) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read port, holds when not reading
    // same-address read/write returns the old word
    always_ff @(posedge i_clk) begin
        if (i_read) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// File: src/tap_dispatch.sv
`timescale 1ns/10ps

module tap_dispatch #(
    parameter int N_LANES = 4,
    parameter int KTAPS   = 9
)(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  conv_pkg::wgt_wr_t              i_wgt,
    input  logic                           i_act_valid,
    input  logic signed [conv_pkg::ACT_W-1:0] i_act,
    output logic [N_LANES-1:0]             o_wr_en,
    output logic [conv_pkg::IDX_W-1:0]     o_wr_idx,
    output logic [conv_pkg::WGT_W-1:0]     o_wr_data,
    output conv_pkg::tap_t                 o_tap
);

    import conv_pkg::*;

    logic [N_LANES-1:0]      wr_dec;       // one-hot lane select
    logic [IDX_W-1:0]        tap_cnt;      // position inside the window
    logic                    last_tap;
    logic                    tap_valid_q;
    logic                    tap_last_q;
    logic [IDX_W-1:0]        tap_idx_q;
    logic signed [ACT_W-1:0] tap_act_q;

    // lanes at or above N_LANES never match, so those writes drop out here
    always_comb begin
        wr_dec = '0;
        for (int l = 0; l < N_LANES; l++) begin
            wr_dec[l] = i_wgt.valid && (int'(i_wgt.lane) == l);
        end
    end

    assign last_tap = (int'(tap_cnt) == KTAPS - 1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_en     <= '0;
            tap_cnt     <= '0;
            tap_valid_q <= 1'b0;
            tap_last_q  <= 1'b0;
        end else begin
            o_wr_en     <= wr_dec;
            tap_valid_q <= i_act_valid;
            tap_last_q  <= i_act_valid && last_tap;
            if (i_act_valid) begin
                tap_cnt <= last_tap ? '0 : tap_cnt + 1'b1;  // wrap after KTAPS-1
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge i_clk) begin
        o_wr_idx  <= i_wgt.idx;
        o_wr_data <= i_wgt.data;
        if (i_act_valid) begin
            tap_idx_q <= tap_cnt;
            tap_act_q <= i_act;
        end
    end

    assign o_tap.valid = tap_valid_q;
    assign o_tap.last  = tap_last_q;
    assign o_tap.idx   = tap_idx_q;
    assign o_tap.act   = tap_act_q;

endmodule

// File: src/mac_lane.sv
`timescale 1ns/10ps

module mac_lane #(
    parameter int RF_WORDS = 12
)(
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_wr_en,
    input  logic [conv_pkg::IDX_W-1:0]        i_wr_idx,
    input  logic [conv_pkg::WGT_W-1:0]        i_wr_data,
    input  conv_pkg::tap_t                    i_tap,
    output logic                              o_done,
    output logic signed [conv_pkg::ACC_W-1:0] o_sum
);

    import conv_pkg::*;

    logic [WGT_W-1:0]              rd_wgt;    // weight for the tap in stage 1
    logic                          s1_valid;
    logic                          s1_last;
    logic                          s1_first;  // tap 0 restarts the sum
    logic signed [ACT_W-1:0]       s1_act;
    logic signed [ACT_W+WGT_W-1:0] prod;
    logic signed [ACC_W-1:0]       acc;

    // kernel weights of this output channel
    rf_2p #(
        .WORDS (RF_WORDS),
        .DWd   (WGT_W)
    ) u_rf (
        .i_clk   (i_clk),
        .i_write (i_wr_en),
        .i_waddr (i_wr_idx),
        .i_wdata (i_wr_data),
        .i_read  (i_tap.valid),
        .i_raddr (i_tap.idx),
        .o_rdata (rd_wgt)
    );

    // stage 1, line the tap up with the rf read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= i_tap.valid;
            s1_last  <= i_tap.valid && i_tap.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tap.valid) begin
            s1_act   <= i_tap.act;
            s1_first <= (i_tap.idx == '0);
        end
    end

    assign prod = s1_act * $signed(rd_wgt);  // full 16-bit signed product

    // stage 2, accumulate
    always_ff @(posedge i_clk) begin
        if (s1_valid) begin
            acc <= s1_first ? ACC_W'(prod) : acc + ACC_W'(prod);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_done <= 1'b0;
        end else begin
            o_done <= s1_last;  // same edge as the final sum
        end
    end

    assign o_sum = acc;

endmodule

// File: src/result_drain.sv
`timescale 1ns/10ps

module result_drain #(
    parameter int N_LANES = 4
)(
    input  logic                                        i_clk,
    input  logic                                        i_reset,
    input  logic                                        i_done,
    input  logic [N_LANES-1:0][conv_pkg::ACC_W-1:0]     i_sums,
    output logic                                        o_res_valid,
    output logic signed [conv_pkg::ACC_W-1:0]           o_res,
    output logic [conv_pkg::LANE_W-1:0]                 o_res_lane
);

    import conv_pkg::*;

    localparam int CNT_W = $clog2(N_LANES + 1);

    logic [CNT_W-1:0]              cnt;     // sums still to send
    logic [LANE_W-1:0]             lane_q;  // lane of the sum at the head
    logic [N_LANES-1:0][ACC_W-1:0] sh;      // lane 0 at the head

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt    <= '0;
            lane_q <= '0;
        end else if (i_done) begin
            cnt    <= CNT_W'(N_LANES);
            lane_q <= '0;
        end else if (cnt != '0) begin
            cnt    <= cnt - 1'b1;
            lane_q <= lane_q + 1'b1;
        end
    end

    // sums move toward lane 0 while sending
    always_ff @(posedge i_clk) begin
        if (i_done) begin
            sh <= i_sums;
        end else if (cnt != '0) begin
            for (int l = 0; l < N_LANES - 1; l++) begin
                sh[l] <= sh[l+1];
            end
        end
    end

    assign o_res_valid = (cnt != '0);
    assign o_res       = sh[0];
    assign o_res_lane  = lane_q;

endmodule

// File: src/conv_engine.sv
`timescale 1ns/10ps

module conv_engine #(
    parameter int N_LANES  = 4,
    parameter int KTAPS    = 9,
    parameter int RF_WORDS = 12
)(
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  conv_pkg::wgt_wr_t                 i_wgt,
    input  logic                              i_act_valid,
    input  logic signed [conv_pkg::ACT_W-1:0] i_act,
    output logic                              o_res_valid,
    output logic signed [conv_pkg::ACC_W-1:0] o_res,
    output logic [conv_pkg::LANE_W-1:0]       o_res_lane
);

    import conv_pkg::*;

    logic [N_LANES-1:0]            wr_en;
    logic [IDX_W-1:0]              wr_idx;
    logic [WGT_W-1:0]              wr_data;
    tap_t                          tap;        // broadcast to every lane
    logic [N_LANES-1:0]            lane_done;  // all lanes finish together
    logic [N_LANES-1:0][ACC_W-1:0] lane_sum;

    tap_dispatch #(
        .N_LANES (N_LANES),
        .KTAPS   (KTAPS)
    ) u_dispatch (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wgt       (i_wgt),
        .i_act_valid (i_act_valid),
        .i_act       (i_act),
        .o_wr_en     (wr_en),
        .o_wr_idx    (wr_idx),
        .o_wr_data   (wr_data),
        .o_tap       (tap)
    );

    // one lane per output channel
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        mac_lane #(
            .RF_WORDS (RF_WORDS)
        ) u_lane (
            .i_clk     (i_clk),
            .i_reset   (i_reset),
            .i_wr_en   (wr_en[g]),
            .i_wr_idx  (wr_idx),
            .i_wr_data (wr_data),
            .i_tap     (tap),
            .o_done    (lane_done[g]),
            .o_sum     (lane_sum[g])
        );
    end

    result_drain #(
        .N_LANES (N_LANES)
    ) u_drain (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_done      (lane_done[0]),  // lane 0 stands for all
        .i_sums      (lane_sum),
        .o_res_valid (o_res_valid),
        .o_res       (o_res),
        .o_res_lane  (o_res_lane)
    );

endmodule

// File: sim/tb_conv_engine.sv
`timescale 1ns/10ps

module tb_conv_engine;

    import conv_pkg::*;

    localparam int N_LANES    = 4;
    localparam int KTAPS      = 9;
    localparam int RF_WORDS   = 12;
    localparam int CLK_PERIOD = 8;
    localparam int MAX_GAP    = 3;                     // most idle cycles after a tap
    localparam int N_WINDOWS  = 10;                    // windows sent over the whole run
    localparam int DRAIN_WAIT = KTAPS + N_LANES + 8;   // cycles allowed for results to appear
    localparam int STIM_CYCLES = 5 + N_LANES * RF_WORDS + 32
                               + N_WINDOWS * (KTAPS * (MAX_GAP + 1) + DRAIN_WAIT);

    // one expected result due at a given clock edge
    typedef struct packed {
        logic [31:0]             due;
        logic [LANE_W-1:0]       lane;
        logic signed [ACC_W-1:0] sum;
    } exp_res_t;

    logic                    i_clk;
    logic                    i_reset;
    wgt_wr_t                 i_wgt;
    logic                    i_act_valid;
    logic signed [ACT_W-1:0] i_act;
    logic                    o_res_valid;
    logic signed [ACC_W-1:0] o_res;
    logic [LANE_W-1:0]       o_res_lane;

    logic [31:0]             rng;                        // lcg state
    logic signed [WGT_W-1:0] wgt_m [N_LANES][RF_WORDS];  // model copy of every lane rf
    int                      acc_m [N_LANES];
    int                      tap_cnt_m;
    int                      cyc;                        // edge counter of the model
    exp_res_t                exp_q [$];
    logic                    exp_valid;
    logic signed [ACC_W-1:0] exp_res;
    logic [LANE_W-1:0]       exp_lane;
    int                      n_expected;                 // results the model predicted
    int                      n_seen;                     // results the DUT sent
    int                      results_due;                // full windows sent, in results
    logic                    chk_en;
    logic signed [ACT_W-1:0] acts [KTAPS];               // taps of the current window

    conv_engine #(
        .N_LANES  (N_LANES),
        .KTAPS    (KTAPS),
        .RF_WORDS (RF_WORDS)
    ) i_conv_engine (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wgt       (i_wgt),
        .i_act_valid (i_act_valid),
        .i_act       (i_act),
        .o_res_valid (o_res_valid),
        .o_res       (o_res),
        .o_res_lane  (o_res_lane)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[23:16];  // upper bits mix better
    endfunction

    // reference model sees the inputs the DUT samples at the same edge
    always @(posedge i_clk) begin : ref_model
        exp_res_t e;
        int       wl;
        int       wi;
        cyc = cyc + 1;
        if (o_res_valid) begin
            n_seen <= n_seen + 1;
        end
        if (i_reset) begin
            tap_cnt_m = 0;
            exp_q.delete();  // results in flight are lost
        end else begin
            // tap before write so a same-edge write is seen one tap later
            if (i_act_valid) begin
                for (int l = 0; l < N_LANES; l++) begin
                    if (tap_cnt_m == 0) begin
                        acc_m[l] = 0;
                    end
                    acc_m[l] = acc_m[l] + int'(i_act) * int'(wgt_m[l][tap_cnt_m]);
                end
                if (tap_cnt_m == KTAPS - 1) begin
                    for (int l = 0; l < N_LANES; l++) begin
                        e.due  = 32'(cyc + 4 + l);
                        e.lane = LANE_W'(l);
                        e.sum  = ACC_W'(acc_m[l]);
                        exp_q.push_back(e);
                    end
                    n_expected <= n_expected + N_LANES;
                    tap_cnt_m = 0;
                end else begin
                    tap_cnt_m = tap_cnt_m + 1;
                end
            end
            wl = int'(i_wgt.lane);
            wi = int'(i_wgt.idx);
            if (i_wgt.valid && wl < N_LANES && wi < RF_WORDS) begin
                wgt_m[wl][wi] = i_wgt.data;
            end
        end
        // what the outputs must show at the next edge
        if (exp_q.size() != 0 && exp_q[0].due == 32'(cyc + 1)) begin
            e = exp_q.pop_front();
            exp_valid <= 1'b1;
            exp_res   <= e.sum;
            exp_lane  <= e.lane;
        end else begin
            exp_valid <= 1'b0;
        end
    end

    property valid_matches;
        @(posedge i_clk) disable iff (!chk_en) o_res_valid == exp_valid;
    endproperty

    property res_matches;
        @(posedge i_clk) disable iff (!chk_en) exp_valid |-> (o_res == exp_res);
    endproperty

    property lane_matches;
        @(posedge i_clk) disable iff (!chk_en) exp_valid |-> (o_res_lane == exp_lane);
    endproperty

    a_valid: assert property (valid_matches)
        else begin
            $display("ERR %0t o_res_valid expected %0b actual %0b",
                     $time, $sampled(exp_valid), $sampled(o_res_valid));
            abort_run();
        end

    a_res: assert property (res_matches)
        else begin
            $display("ERR %0t o_res expected %0d actual %0d",
                     $time, $sampled(exp_res), $sampled(o_res));
            abort_run();
        end

    a_lane: assert property (lane_matches)
        else begin
            $display("ERR %0t o_res_lane expected %0d actual %0d",
                     $time, $sampled(exp_lane), $sampled(o_res_lane));
            abort_run();
        end

    task automatic drive_idle();
        @(posedge i_clk);
        i_wgt       <= '0;
        i_act_valid <= 1'b0;
        i_act       <= '0;
    endtask

    task automatic drive_tap(input logic signed [ACT_W-1:0] act);
        @(posedge i_clk);
        i_wgt       <= '0;
        i_act_valid <= 1'b1;
        i_act       <= act;
    endtask

    task automatic drive_write(input int lane, input int idx, input logic [WGT_W-1:0] data);
        wgt_wr_t w;
        w.valid = 1'b1;
        w.lane  = LANE_W'(lane);
        w.idx   = IDX_W'(idx);
        w.data  = data;
        @(posedge i_clk);
        i_wgt       <= w;
        i_act_valid <= 1'b0;
        i_act       <= '0;
    endtask

    task automatic load_all_weights();
        for (int l = 0; l < N_LANES; l++) begin
            for (int i = 0; i < RF_WORDS; i++) begin
                drive_write(l, i, rand_byte());
            end
        end
    endtask

    task automatic overwrite_weights(input int count);
        int lane;
        int idx;
        repeat (count) begin
            lane = int'(rand_byte()) % N_LANES;
            idx  = int'(rand_byte()) % KTAPS;
            drive_write(lane, idx, rand_byte());
        end
    endtask

    // writes to lanes that do not exist must be dropped
    task automatic stray_writes();
        for (int l = N_LANES; l < (1 << LANE_W); l++) begin
            drive_write(l, int'(rand_byte()) % KTAPS, rand_byte());
        end
    endtask

    task automatic fill_acts();
        for (int t = 0; t < KTAPS; t++) begin
            acts[t] = rand_byte();
        end
    endtask

    task automatic send_taps(input int count, input int max_gap);
        int gap;
        for (int t = 0; t < count; t++) begin
            drive_tap(acts[t]);
            if (max_gap > 0) begin
                gap = int'(rand_byte()) % (max_gap + 1);
                repeat (gap) drive_idle();
            end
        end
    endtask

    task automatic send_window(input int max_gap);
        send_taps(KTAPS, max_gap);
        results_due = results_due + N_LANES;
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge i_clk);
        i_reset     <= 1'b1;
        i_wgt       <= '0;
        i_act_valid <= 1'b0;
        repeat (cycles) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (n_seen != results_due && waited < DRAIN_WAIT) begin
            drive_idle();
            waited++;
        end
        if (n_seen != results_due) begin
            $display("results missing, %0d of %0d arrived after %0d cycles",
                     n_seen, results_due, waited);
            abort_run();
        end
    endtask

    initial begin : watchdog
        #((STIM_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in %0d cycles", STIM_CYCLES + 100);
        abort_run();
    end

    initial begin : stimulus
        rng         = 32'hf83c_caf9;
        i_reset     = 1'b1;
        i_wgt       = '0;
        i_act_valid = 1'b0;
        i_act       = '0;
        chk_en      = 1'b0;
        cyc         = 0;
        tap_cnt_m   = 0;
        n_expected  = 0;
        n_seen      = 0;
        results_due = 0;
        exp_valid   = 1'b0;
        exp_res     = '0;
        exp_lane    = '0;
        for (int l = 0; l < N_LANES; l++) begin
            acc_m[l] = 0;
            for (int i = 0; i < RF_WORDS; i++) begin
                wgt_m[l][i] = '0;
            end
        end
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        chk_en  <= 1'b1;

        // all lanes loaded and then a single window
        load_all_weights();
        fill_acts();
        send_window(0);
        wait_results();

        // back to back windows where tap 0 has to restart the sum
        repeat (3) begin
            fill_acts();
            send_window(0);
        end
        wait_results();

        // same taps with and without idle gaps
        fill_acts();
        send_window(0);
        send_window(MAX_GAP);
        wait_results();
        fill_acts();
        send_window(MAX_GAP);
        wait_results();

        // a few new weights plus writes to lanes that are not built
        overwrite_weights(6);
        stray_writes();
        fill_acts();
        send_window(0);
        wait_results();

        // reset in the middle of a window
        fill_acts();
        send_taps(5, 0);
        apply_reset(3);
        drive_idle();
        fill_acts();
        send_window(1);
        wait_results();

        repeat (N_LANES + 4) drive_idle();
        if (n_seen == results_due && n_expected == results_due && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("result count mismatch, DUT sent %0d, model expected %0d, windows gave %0d",
                     n_seen, n_expected, results_due);
            abort_run();
        end
    end

endmodule

// File: build.f
src/conv_pkg.sv
src/rf_2p.sv
src/tap_dispatch.sv
src/mac_lane.sv
src/result_drain.sv
src/conv_engine.sv
sim/tb_conv_engine.sv

// File: run.sh
#!/bin/sh
# compile with verilator, run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_engine -f build.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_conv_engine | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
